/* source/tdc_meas_pkg.sv */
// TDC measurement package with sample word, pulse length and channel state types
`default_nettype none

package tdc_meas_pkg;

    // Deserialized input word
    localparam int SAMPLES_PER_WORD = 16;            // Samples per DV_CLK cycle

    typedef logic [SAMPLES_PER_WORD-1:0] sample_word_t; // Bit 0 is the earliest sample

    // Number of ones found in one word, 0 to 16
    typedef logic [4:0] word_cnt_t;

    // Pulse length in samples
    typedef logic [11:0] tdc_value_t;                // 0 is error, 4095 is overflow
    typedef logic [12:0] tdc_acc_t;                  // Accumulator with overflow bit

    localparam tdc_acc_t TDC_MAX = 13'd4095;         // Saturation value

    typedef logic [15:0] timestamp_t;
    typedef logic [15:0] event_cnt_t;                // Per channel event number
    typedef logic        chan_id_t;

    typedef enum logic [1:0] {
        IDLE,                                        // Waiting for a pulse or an arm
        ARMED,                                       // Armed for a single measurement
        COUNT,                                       // Pulse spans word boundary
        HANDSHAKE                                    // Record handed to the arbiter
    } chan_state_t;

endpackage

`default_nettype wire

/* source/tdc_bus_pkg.sv */
// TDC bus package with the event record, configuration and host register map
`default_nettype none

package tdc_bus_pkg;

    import tdc_meas_pkg::*;

    typedef logic [3:0] data_id_t;

    localparam data_id_t DATA_IDENTIFIER_BASE = 4'b0100; // Channel 1 adds one

    // Record as written to the event FIFO
    typedef struct packed {
        data_id_t   identifier;
        timestamp_t stamp;                           // Event count or timestamp
        tdc_value_t value;
    } tdc_record_t;

    typedef struct packed {
        logic [3:0] spare;
        logic       invert;                          // Invert input samples
        logic       write_ts;                        // Stamp holds timestamp
        logic       arm_mode;                        // Single measurement after arm
        logic       enable;
    } tdc_config_t;

    // Host bus
    typedef logic [7:0] bus_addr_t;
    typedef logic [7:0] bus_data_t;

    localparam bus_addr_t ADDR_RESET_VERSION = 8'd0;
    localparam bus_addr_t ADDR_CONFIG        = 8'd1;
    localparam bus_addr_t ADDR_EVENT_LO      = 8'd2;
    localparam bus_addr_t ADDR_EVENT_HI      = 8'd3;
    localparam bus_addr_t ADDR_LOST          = 8'd4;
    localparam bus_addr_t ADDR_FILL          = 8'd5;

    localparam bus_data_t VERSION = 8'd2;

    typedef logic [31:0] event_total_t;              // Finished events of all channels

    // Event FIFO
    localparam int FIFO_DEPTH = 8;
    typedef logic [2:0] fifo_ptr_t;
    typedef logic [3:0] fifo_level_t;
    typedef logic [7:0] lost_cnt_t;                  // Saturating

    localparam int NUM_CHANNELS = 2;

endpackage

`default_nettype wire

/* source/tdc_channel.sv */
// TDC channel measuring pulse lengths in samples and handing records to the arbiter
`timescale 1ns/1ps
`default_nettype none

module tdc_channel import tdc_meas_pkg::*, tdc_bus_pkg::*; (
    input  wire logic        DV_CLK,
    input  wire logic        RST_SYNC,
    input  wire sample_word_t samples,
    input  wire chan_id_t    chan,                   // Tied at the top
    input  wire tdc_config_t cfg,
    input  wire logic        arm,
    input  wire timestamp_t  timestamp,
    input  wire logic        clear,
    output logic             finish,
    output logic             rec_req,
    input  wire logic        rec_ack,
    output tdc_record_t      rec
);

    chan_state_t  state;
    sample_word_t word;
    word_cnt_t    ones;                              // Ones of the pulse in this word
    logic         seen;
    logic         edge_seen;                         // Pulse ended inside this word
    logic         multi_err;                         // Another one after the falling edge
    logic         start_ok;
    logic         pulse_end;
    tdc_acc_t     acc;
    tdc_acc_t     acc_sum;
    tdc_acc_t     acc_next;
    timestamp_t   ts_start;
    timestamp_t   ts_sel;
    event_cnt_t   event_cnt;
    tdc_record_t  rec_next;

    // Scan the word from the earliest sample
    always_comb begin
        word      = cfg.invert ? ~samples : samples;
        seen      = (state == COUNT);                // Running pulse continues at bit 0
        edge_seen = 1'b0;
        multi_err = 1'b0;
        ones      = '0;
        for (int i = 0; i < SAMPLES_PER_WORD; i++) begin
            if (word[i]) begin
                if (edge_seen) begin
                    multi_err = 1'b1;
                end else begin
                    seen = 1'b1;
                    ones = ones + 1'b1;
                end
            end else if (seen) begin
                edge_seen = 1'b1;
            end
        end
    end

    assign start_ok  = cfg.enable && (|word) &&
                       ((state == IDLE && !cfg.arm_mode) || state == ARMED);
    assign pulse_end = (start_ok || state == COUNT) && edge_seen;
    assign finish    = pulse_end;

    // Length so far, restarted when a new pulse begins
    assign acc_sum  = ((state == COUNT) ? acc : '0) + tdc_acc_t'(ones);
    assign acc_next = (acc_sum > TDC_MAX) ? TDC_MAX : acc_sum; // Clamp overflow

    assign ts_sel = (state == COUNT) ? ts_start : timestamp;

    always_comb begin
        rec_next.identifier = DATA_IDENTIFIER_BASE + data_id_t'(chan);
        rec_next.stamp      = cfg.write_ts ? ts_sel : event_cnt + 1'b1;
        rec_next.value      = multi_err ? '0 : tdc_value_t'(acc_next);
    end

    always_ff @(posedge DV_CLK) begin
        if (RST_SYNC || clear) begin
            state     <= IDLE;
            rec_req   <= 1'b0;
            event_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (pulse_end) begin
                        state <= HANDSHAKE;
                    end else if (start_ok) begin
                        state <= COUNT;
                    end else if (cfg.enable && cfg.arm_mode && arm) begin
                        state <= ARMED;
                    end
                end
                ARMED: begin
                    if (pulse_end) begin
                        state <= HANDSHAKE;
                    end else if (start_ok) begin
                        state <= COUNT;
                    end else if (!cfg.enable) begin
                        state <= IDLE;               // Disarm when disabled
                    end
                end
                COUNT: begin
                    if (pulse_end) begin
                        state <= HANDSHAKE;
                    end
                end
                HANDSHAKE: begin
                    if (rec_req && rec_ack) begin
                        rec_req <= 1'b0;             // Record taken
                    end else if (!rec_req && !rec_ack) begin
                        state <= IDLE;               // Arbiter released ack
                    end
                end
                default: state <= IDLE;
            endcase
            if (pulse_end) begin
                rec_req   <= 1'b1;
                event_cnt <= event_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge DV_CLK) begin
        if (start_ok || state == COUNT) begin
            acc <= acc_next;
        end
        if (start_ok) begin
            ts_start <= timestamp;
        end
        if (pulse_end) begin
            rec <= rec_next;                         // Held while req is high
        end
    end

endmodule

`default_nettype wire

/* source/tdc_write_arbiter.sv */
// Round-robin arbiter taking channel records by req/ack and writing them to the FIFO
`timescale 1ns/1ps
`default_nettype none

module tdc_write_arbiter import tdc_meas_pkg::*, tdc_bus_pkg::*; (
    input  wire logic                    DV_CLK,
    input  wire logic                    RST_SYNC,
    input  wire logic [NUM_CHANNELS-1:0] rec_req,
    input  wire tdc_record_t             rec [NUM_CHANNELS],
    output logic [NUM_CHANNELS-1:0]      rec_ack,
    output logic                         wr_en,
    output tdc_record_t                  wr_data
);

    chan_id_t last;                                  // Channel served last
    chan_id_t grant_idx;
    logic     grant_valid;

    // First requester after the last served one
    always_comb begin
        chan_id_t idx;
        grant_valid = 1'b0;
        grant_idx   = last;
        for (int i = 1; i <= NUM_CHANNELS; i++) begin
            idx = chan_id_t'(int'(last) + i);
            if (!grant_valid && rec_req[idx]) begin
                grant_valid = 1'b1;
                grant_idx   = idx;
            end
        end
    end

    always_ff @(posedge DV_CLK) begin
        if (RST_SYNC) begin
            rec_ack <= '0;
            wr_en   <= 1'b0;
            last    <= chan_id_t'(NUM_CHANNELS - 1); // Channel 0 first
        end else begin
            wr_en <= 1'b0;
            if (|rec_ack) begin
                rec_ack <= rec_ack & rec_req;        // Hold ack until req drops
            end else if (grant_valid) begin
                rec_ack[grant_idx] <= 1'b1;
                wr_en              <= 1'b1;          // Single write per handshake
                last               <= grant_idx;
            end
        end
    end

    always_ff @(posedge DV_CLK) begin
        if (!(|rec_ack) && grant_valid) begin
            wr_data <= rec[grant_idx];
        end
    end

endmodule

`default_nettype wire

/* source/tdc_event_fifo.sv */
// Shared event FIFO with show-ahead read port, fill level and lost record counter
`timescale 1ns/1ps
`default_nettype none

module tdc_event_fifo import tdc_bus_pkg::*; (
    input  wire logic        DV_CLK,
    input  wire logic        RST_SYNC,
    input  wire logic        wr_en,
    input  wire tdc_record_t wr_data,
    input  wire logic        clear,
    input  wire logic        fifo_read,
    output logic             fifo_empty,
    output tdc_record_t      fifo_data,
    output fifo_level_t      fill,
    output lost_cnt_t        lost_cnt
);

    tdc_record_t mem [FIFO_DEPTH];
    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_level_t level;
    logic        full;
    logic        do_wr;
    logic        do_rd;

    assign full       = (level == fifo_level_t'(FIFO_DEPTH));
    assign fifo_empty = (level == '0);
    assign fifo_data  = mem[rd_ptr];                 // Oldest record shown ahead
    assign fill       = level;

    assign do_wr = wr_en && !full;
    assign do_rd = fifo_read && !fifo_empty;

    always_ff @(posedge DV_CLK) begin
        if (RST_SYNC || clear) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            level    <= '0;
            lost_cnt <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;             // Wraps at depth
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
            if (wr_en && full && lost_cnt != '1) begin
                lost_cnt <= lost_cnt + 1'b1;         // Record dropped
            end
        end
    end

    always_ff @(posedge DV_CLK) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* source/tdc_regs.sv */
// Host register file with configuration, soft clear, version, event and lost counters
`timescale 1ns/1ps
`default_nettype none

module tdc_regs import tdc_meas_pkg::*, tdc_bus_pkg::*; (
    input  wire logic                    DV_CLK,
    input  wire logic                    RST_SYNC,
    input  wire bus_addr_t               bus_addr,
    input  wire logic                    bus_wr,
    input  wire logic                    bus_rd,
    input  wire bus_data_t               bus_wdata,
    output bus_data_t                    bus_rdata,
    input  wire logic [NUM_CHANNELS-1:0] finish,
    input  wire fifo_level_t             fill,
    input  wire lost_cnt_t               lost_cnt,
    output tdc_config_t                  cfg,
    output logic                         clear
);

    event_total_t event_total;
    event_cnt_t   event_view;                        // Saturated low part of the total
    event_cnt_t   event_snap;                        // Latched on low byte read

    assign clear = bus_wr && (bus_addr == ADDR_RESET_VERSION); // Soft clear pulse

    assign event_view = (|event_total[31:16]) ? '1 : event_total[15:0];

    always_ff @(posedge DV_CLK) begin
        if (RST_SYNC || clear) begin
            cfg <= '0;
        end else if (bus_wr && bus_addr == ADDR_CONFIG) begin
            cfg <= tdc_config_t'(bus_wdata);
        end
    end

    // Both channels may finish in the same cycle
    always_ff @(posedge DV_CLK) begin
        if (RST_SYNC || clear) begin
            event_total <= '0;
            event_snap  <= '0;
        end else begin
            event_total <= event_total + event_total_t'(finish[0]) +
                           event_total_t'(finish[1]);
            if (bus_rd && bus_addr == ADDR_EVENT_LO) begin
                event_snap <= event_view;
            end
        end
    end

    always_ff @(posedge DV_CLK) begin
        if (RST_SYNC) begin
            bus_rdata <= '0;
        end else if (bus_rd) begin
            case (bus_addr)
                ADDR_RESET_VERSION: bus_rdata <= VERSION;
                ADDR_CONFIG:        bus_rdata <= bus_data_t'(cfg);
                ADDR_EVENT_LO:      bus_rdata <= event_view[7:0];
                ADDR_EVENT_HI:      bus_rdata <= event_snap[15:8]; // Same snapshot
                ADDR_LOST:          bus_rdata <= lost_cnt;
                ADDR_FILL:          bus_rdata <= bus_data_t'(fill);
                default:            bus_rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/tdc_top.sv */
// Two-channel TDC readout joining channels, write arbiter, event FIFO and registers
`timescale 1ns/1ps
`default_nettype none

module tdc_top import tdc_meas_pkg::*, tdc_bus_pkg::*; (
    input  wire logic         DV_CLK,
    input  wire logic         RST_SYNC,
    input  wire sample_word_t samples0,
    input  wire sample_word_t samples1,
    input  wire logic         arm,
    input  wire timestamp_t   timestamp,
    input  wire bus_addr_t    bus_addr,
    input  wire logic         bus_wr,
    input  wire logic         bus_rd,
    input  wire bus_data_t    bus_wdata,
    output bus_data_t         bus_rdata,
    input  wire logic         fifo_read,
    output logic              fifo_empty,
    output tdc_record_t       fifo_data
);

    sample_word_t              samples_arr [NUM_CHANNELS];
    tdc_config_t               cfg;
    logic                      clear;
    logic [NUM_CHANNELS-1:0]   finish;
    logic [NUM_CHANNELS-1:0]   rec_req;
    logic [NUM_CHANNELS-1:0]   rec_ack;
    tdc_record_t               rec [NUM_CHANNELS];
    logic                      wr_en;
    tdc_record_t               wr_data;
    fifo_level_t               fill;
    lost_cnt_t                 lost_cnt;

    assign samples_arr[0] = samples0;
    assign samples_arr[1] = samples1;

    for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_chan
        tdc_channel i_tdc_channel (
            .DV_CLK    (DV_CLK),
            .RST_SYNC  (RST_SYNC),
            .samples   (samples_arr[g]),
            .chan      (chan_id_t'(g)),              // Selects the record identifier
            .cfg       (cfg),
            .arm       (arm),
            .timestamp (timestamp),
            .clear     (clear),
            .finish    (finish[g]),
            .rec_req   (rec_req[g]),
            .rec_ack   (rec_ack[g]),
            .rec       (rec[g])
        );
    end

    tdc_write_arbiter i_tdc_write_arbiter (
        .DV_CLK   (DV_CLK),
        .RST_SYNC (RST_SYNC),
        .rec_req  (rec_req),
        .rec      (rec),
        .rec_ack  (rec_ack),
        .wr_en    (wr_en),
        .wr_data  (wr_data)
    );

    tdc_event_fifo i_tdc_event_fifo (
        .DV_CLK     (DV_CLK),
        .RST_SYNC   (RST_SYNC),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .clear      (clear),
        .fifo_read  (fifo_read),
        .fifo_empty (fifo_empty),
        .fifo_data  (fifo_data),
        .fill       (fill),
        .lost_cnt   (lost_cnt)
    );

    tdc_regs i_tdc_regs (
        .DV_CLK    (DV_CLK),
        .RST_SYNC  (RST_SYNC),
        .bus_addr  (bus_addr),
        .bus_wr    (bus_wr),
        .bus_rd    (bus_rd),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata),
        .finish    (finish),
        .fill      (fill),
        .lost_cnt  (lost_cnt),
        .cfg       (cfg),
        .clear     (clear)
    );

endmodule

`default_nettype wire

/* tests/tdc_arbiter_sva.sv */
// Handshake assertions for the round-robin write arbiter, bound into the arbiter
`timescale 1ns/1ps
`default_nettype none

module tdc_arbiter_sva import tdc_bus_pkg::*; (
    input wire logic                    DV_CLK,
    input wire logic                    RST_SYNC,
    input wire logic [NUM_CHANNELS-1:0] rec_req,
    input wire logic [NUM_CHANNELS-1:0] rec_ack
);

    a_one_ack: assert property (@(posedge DV_CLK) disable iff (RST_SYNC) $onehot0(rec_ack))
        else $error("More than one channel acknowledged at once: %b", rec_ack);

    for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_chan
        // Ack follows req one cycle late on both edges
        a_ack_only_while_req: assert property (
            @(posedge DV_CLK) disable iff (RST_SYNC)
            rec_ack[g] |-> $past(rec_req[g]))
            else $error("Ack on channel %0d without a pending req", g);

        a_req_held_until_ack: assert property (
            @(posedge DV_CLK) disable iff (RST_SYNC)
            rec_req[g] && !rec_ack[g] |=> rec_req[g])
            else $error("Req on channel %0d dropped before its ack", g);
    end

endmodule

bind tdc_write_arbiter tdc_arbiter_sva i_tdc_arbiter_sva (
    .DV_CLK   (DV_CLK),
    .RST_SYNC (RST_SYNC),
    .rec_req  (rec_req),
    .rec_ack  (rec_ack)
);

`default_nettype wire

/* tests/tdc_tb.sv */
// Directed testbench for the two-channel TDC readout covering records, registers and FIFO
`timescale 1ns/1ps
`default_nettype none

module tdc_tb import tdc_meas_pkg::*, tdc_bus_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int PULSE_GAP   = 8;                  // Idle words after every pulse
    localparam int RECORD_WAIT = 20;
    localparam int LONG_PULSE  = 4200;               // Beyond the 4095 sample range
    localparam int FULL_PULSES = 10;
    // Overflow pulse dominates, the other tests need a few hundred cycles
    localparam int CYCLE_LIMIT = 2 * (LONG_PULSE / SAMPLES_PER_WORD + 400);

    logic         DV_CLK;
    logic         RST_SYNC;
    sample_word_t samples0;
    sample_word_t samples1;
    logic         arm;
    timestamp_t   timestamp;
    bus_addr_t    bus_addr;
    logic         bus_wr;
    logic         bus_rd;
    bus_data_t    bus_wdata;
    bus_data_t    bus_rdata;
    logic         fifo_read;
    logic         fifo_empty;
    tdc_record_t  fifo_data;

    logic [31:0]  lfsr;
    timestamp_t   ts_next;                           // Driven with the next word
    timestamp_t   start_ts;                          // Seen with the first pulse word
    event_cnt_t   ev_cnt [NUM_CHANNELS];             // Expected event numbers
    int           cycle_cnt;
    int           errors;
    int           test_errors;
    int           tests_run;
    int           tests_failed;

    tdc_top i_tdc_top (
        .DV_CLK     (DV_CLK),
        .RST_SYNC   (RST_SYNC),
        .samples0   (samples0),
        .samples1   (samples1),
        .arm        (arm),
        .timestamp  (timestamp),
        .bus_addr   (bus_addr),
        .bus_wr     (bus_wr),
        .bus_rd     (bus_rd),
        .bus_wdata  (bus_wdata),
        .bus_rdata  (bus_rdata),
        .fifo_read  (fifo_read),
        .fifo_empty (fifo_empty),
        .fifo_data  (fifo_data)
    );

    initial DV_CLK = 1'b0;
    always #(CLK_PERIOD / 2) DV_CLK = ~DV_CLK;

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v    = (v << 1) | int'(lfsr[0]);         // One step per bit
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic sample_word_t pulse_word(input int off, input int len, input int idx);
        sample_word_t w;
        int           p;
        w = '0;
        for (int b = 0; b < SAMPLES_PER_WORD; b++) begin
            p    = idx * SAMPLES_PER_WORD + b;
            w[b] = (p >= off) && (p < off + len);
        end
        return w;
    endfunction

    function automatic tdc_record_t make_record(input int ch, input timestamp_t stamp,
                                                input int len);
        tdc_record_t r;
        r.identifier = DATA_IDENTIFIER_BASE + data_id_t'(ch);
        r.stamp      = stamp;
        r.value      = (len > 4095) ? 12'd4095 : tdc_value_t'(len); // Saturated length
        return r;
    endfunction

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("%s passed", name);
        end else begin
            tests_failed++;
            $display("%s failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic check_byte(input string name, input bus_data_t exp, input bus_data_t act);
        if (act !== exp) begin
            $display("** Error: %s expected %h actual %h", name, exp, act);
            note_error();
        end
    endtask

    task automatic check_record(input string name, input tdc_record_t exp,
                                input tdc_record_t act);
        if (act !== exp) begin
            $display("** Error: %s expected id/stamp/value %h/%h/%0d actual %h/%h/%0d",
                     name, exp.identifier, exp.stamp, exp.value,
                     act.identifier, act.stamp, act.value);
            note_error();
        end
    endtask

    task automatic drive_words(input sample_word_t w0, input sample_word_t w1);
        @(posedge DV_CLK);
        samples0  <= w0;
        samples1  <= w1;
        timestamp <= ts_next;
        ts_next   = ts_next + 16'd3;
    endtask

    task automatic quiet(input int n);
        repeat (n) drive_words('0, '0);
    endtask

    // Length 0 keeps a channel quiet
    task automatic send_pulses(input int off0, input int len0, input int off1, input int len1);
        int n0;
        int n1;
        n0       = (len0 > 0) ? (off0 + len0) / SAMPLES_PER_WORD + 1 : 0;
        n1       = (len1 > 0) ? (off1 + len1) / SAMPLES_PER_WORD + 1 : 0;
        start_ts = ts_next;
        for (int i = 0; i < ((n0 > n1) ? n0 : n1); i++) begin
            drive_words(pulse_word(off0, len0, i), pulse_word(off1, len1, i));
        end
        quiet(PULSE_GAP);
    endtask

    task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
        @(posedge DV_CLK);
        bus_addr  <= addr;
        bus_wdata <= data;
        bus_wr    <= 1'b1;
        @(posedge DV_CLK);
        bus_wr    <= 1'b0;
    endtask

    task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
        @(posedge DV_CLK);
        bus_addr <= addr;
        bus_rd   <= 1'b1;
        @(posedge DV_CLK);
        bus_rd   <= 1'b0;
        @(negedge DV_CLK);
        data = bus_rdata;                            // Registered one cycle after bus_rd
    endtask

    task automatic soft_clear();
        bus_write(ADDR_RESET_VERSION, 8'h00);
        ev_cnt[0] = '0;
        ev_cnt[1] = '0;
    endtask

    task automatic read_record(input string name, output tdc_record_t r, output logic got);
        int waited;
        waited = 0;
        got    = 1'b0;
        r      = '0;
        @(negedge DV_CLK);
        while (fifo_empty && waited < RECORD_WAIT) begin
            @(negedge DV_CLK);
            waited++;
        end
        if (fifo_empty) begin
            $display("%s: no record arrived within %0d cycles", name, RECORD_WAIT);
            note_error();
        end else begin
            got = 1'b1;
            r   = fifo_data;                         // Show-ahead output
            @(posedge DV_CLK);
            fifo_read <= 1'b1;
            @(posedge DV_CLK);
            fifo_read <= 1'b0;
        end
    endtask

    task automatic expect_record(input string name, input int ch, input timestamp_t stamp,
                                 input int len);
        tdc_record_t act;
        logic        got;
        read_record(name, act, got);
        if (got) begin
            check_record(name, make_record(ch, stamp, len), act);
        end
    endtask

    task automatic test_regs();
        bus_data_t d;
        int        off;
        bus_read(ADDR_RESET_VERSION, d);
        check_byte("test_regs version", VERSION, d);
        bus_write(ADDR_CONFIG, 8'ha5);
        bus_read(ADDR_CONFIG, d);
        check_byte("test_regs config", 8'ha5, d);
        rand_bits(4, off);
        send_pulses(off, 5, 0, 0);                   // Leaves one record to clear
        soft_clear();
        bus_read(ADDR_CONFIG, d);
        check_byte("test_regs config after clear", 8'h00, d);
        if (!fifo_empty) begin
            $display("test_regs: FIFO still holds records after the soft clear");
            note_error();
        end
        finish_test("test_regs");
    endtask

    task automatic test_single_pulse();
        int lens [4] = '{5, 16, 37, 100};
        int off;
        bus_write(ADDR_CONFIG, 8'h01);
        foreach (lens[i]) begin
            rand_bits(4, off);
            send_pulses(off, lens[i], 0, 0);
            ev_cnt[0] = ev_cnt[0] + 16'd1;
            expect_record("test_single_pulse", 0, ev_cnt[0], lens[i]);
        end
        finish_test("test_single_pulse");
    endtask

    task automatic test_error_overflow();
        int off;
        drive_words(16'h071c, 16'h0000);             // Ones at 2 to 4 and again at 8 to 10
        quiet(PULSE_GAP);
        ev_cnt[0] = ev_cnt[0] + 16'd1;
        expect_record("test_error_overflow double", 0, ev_cnt[0], 0);
        rand_bits(4, off);
        send_pulses(off, LONG_PULSE, 0, 0);
        ev_cnt[0] = ev_cnt[0] + 16'd1;
        expect_record("test_error_overflow long", 0, ev_cnt[0], LONG_PULSE);
        finish_test("test_error_overflow");
    endtask

    task automatic test_arm_timestamp();
        int off;
        bus_write(ADDR_CONFIG, 8'h07);               // Enable, arm mode and timestamp stamp
        rand_bits(4, off);
        send_pulses(off, 6, 0, 0);
        @(negedge DV_CLK);
        if (!fifo_empty) begin
            $display("test_arm_timestamp: a pulse without arm produced a record");
            note_error();
        end
        @(posedge DV_CLK);
        arm <= 1'b1;
        @(posedge DV_CLK);
        arm <= 1'b0;
        rand_bits(4, off);
        send_pulses(off, 40, 0, 0);                  // Spans several words
        ev_cnt[0] = ev_cnt[0] + 16'd1;
        expect_record("test_arm_timestamp", 0, start_ts, 40);
        finish_test("test_arm_timestamp");
    endtask

    task automatic test_contention();
        int          off;
        int          ch;
        int          lens [2];
        logic [1:0]  seen;
        logic        got;
        tdc_record_t r;
        bus_data_t   d;
        soft_clear();
        bus_write(ADDR_CONFIG, 8'h01);
        rand_bits(3, off);
        lens = '{20 - off, 16 - off};                // Both pulses end at sample 20
        send_pulses(off, lens[0], off + 4, lens[1]);
        ev_cnt[0] = ev_cnt[0] + 16'd1;
        ev_cnt[1] = ev_cnt[1] + 16'd1;
        seen = '0;
        for (int k = 0; k < 2; k++) begin
            read_record("test_contention", r, got);
            if (got) begin
                ch = (r.identifier == DATA_IDENTIFIER_BASE) ? 0 : 1;
                if (seen[ch]) begin
                    $display("test_contention: two records came from channel %0d", ch);
                    note_error();
                end
                seen[ch] = 1'b1;
                check_record("test_contention", make_record(ch, ev_cnt[ch], lens[ch]), r);
            end
        end
        bus_read(ADDR_EVENT_LO, d);
        check_byte("test_contention events low", 8'd2, d);
        bus_read(ADDR_EVENT_HI, d);
        check_byte("test_contention events high", 8'd0, d);
        finish_test("test_contention");
    endtask

    task automatic test_fifo_full();
        int        off;
        bus_data_t d;
        soft_clear();
        bus_write(ADDR_CONFIG, 8'h01);
        for (int k = 0; k < FULL_PULSES; k++) begin
            rand_bits(4, off);
            send_pulses(off, k + 3, 0, 0);
        end
        bus_read(ADDR_FILL, d);
        check_byte("test_fifo_full fill", bus_data_t'(FIFO_DEPTH), d);
        bus_read(ADDR_LOST, d);
        check_byte("test_fifo_full lost", bus_data_t'(FULL_PULSES - FIFO_DEPTH), d);
        for (int k = 0; k < FIFO_DEPTH; k++) begin
            ev_cnt[0] = ev_cnt[0] + 16'd1;
            expect_record("test_fifo_full", 0, ev_cnt[0], k + 3);
        end
        @(negedge DV_CLK);
        if (!fifo_empty) begin
            $display("test_fifo_full: FIFO not empty after reading all records");
            note_error();
        end
        finish_test("test_fifo_full");
    endtask

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge DV_CLK);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", CYCLE_LIMIT);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        RST_SYNC     = 1'b1;
        samples0     = '0;
        samples1     = '0;
        arm          = 1'b0;
        timestamp    = '0;
        bus_addr     = '0;
        bus_wr       = 1'b0;
        bus_rd       = 1'b0;
        bus_wdata    = '0;
        fifo_read    = 1'b0;
        lfsr         = 32'he1577223;
        ts_next      = 16'h1200;
        ev_cnt[0]    = '0;
        ev_cnt[1]    = '0;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (2) @(posedge DV_CLK);
        RST_SYNC <= 1'b0;
        test_regs();
        test_single_pulse();
        test_error_overflow();
        test_arm_timestamp();
        test_contention();
        test_fifo_full();
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
source/tdc_meas_pkg.sv
source/tdc_bus_pkg.sv
source/tdc_channel.sv
source/tdc_write_arbiter.sv
source/tdc_event_fifo.sv
source/tdc_regs.sv
source/tdc_top.sv
tests/tdc_arbiter_sva.sv
tests/tdc_tb.sv

/* Makefile */
SIM  := obj_dir/Vtdc_tb
SRCS := $(shell cat src.f)

.PHONY: all run clean

all: run

$(SIM): src.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tdc_tb -f src.f -o Vtdc_tb

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then exit 1; fi
	@grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
